// ==== hw/rr_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// record/replay shared definitions
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package rr_pkg;

  //////////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////////

  // replayed channels and payload width
  localparam int CHANNEL_CNT = 2;
  localparam int DATA_WIDTH = 16;

  // input buffering
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

  // happen-before window
  localparam int MERGE_TREE_HEIGHT = 2;
  localparam int REPLAYER_PIPE_DEPTH = 2;
  // end events that may be in flight between runtime and log
  localparam int ON_THE_FLY_CNT = MERGE_TREE_HEIGHT + REPLAYER_PIPE_DEPTH;
  // holds 2x the window, plus a sign bit for rt - replay
  localparam int PKT_CNT_WIDTH = $clog2(2 * ON_THE_FLY_CNT) + 1;

  //////////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////////

  typedef logic [DATA_WIDTH-1:0]     logb_data_t;
  typedef logic [CHANNEL_CNT-1:0]    loge_vec_t;
  typedef logic [PKT_CNT_WIDTH-1:0]  pkt_cnt_t;
  typedef logic [FIFO_PTR_WIDTH-1:0] fifo_ptr_t;
  typedef logic [FIFO_CNT_WIDTH-1:0] fifo_cnt_t;

  // one channel's share of a replay word
  typedef struct packed {
    logic       logb_valid;
    logb_data_t logb_data;
    // end markers seen up to this packet, one per channel
    loge_vec_t  loge_valid;
  } chan_pkt_t;

  // element c belongs to channel c
  typedef chan_pkt_t [CHANNEL_CNT-1:0] replay_word_t;

  // replayer skid buffer occupancy
  typedef enum logic [1:0] {
    EMPTY,
    BUSY,
    FULL
  } rr_state_t;

endpackage

`default_nettype wire

// ==== hw/rr_replay_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// replay word input FIFO
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module rr_replay_fifo (
  input  wire                  clk,
  input  wire                  rstn,
  // write side
  input  wire                  i_wr_valid,
  input  wire rr_pkg::replay_word_t i_wr_word,
  output logic                 o_wr_ready,
  // read side, registered
  output logic                 o_rd_valid,
  output rr_pkg::replay_word_t o_rd_word,
  input  wire                  i_rd_ready
);

  // circular storage behind the read register
  rr_pkg::replay_word_t mem [rr_pkg::FIFO_DEPTH];
  rr_pkg::fifo_ptr_t    wr_ptr;
  rr_pkg::fifo_ptr_t    rd_ptr;
  rr_pkg::fifo_cnt_t    mem_cnt;
  rr_pkg::fifo_cnt_t    mem_cnt_next;
  // total words held, read register included
  rr_pkg::fifo_cnt_t    occ_next;

  logic wr_fire;
  logic out_load;
  logic pop;
  logic bypass;
  logic push;
  logic rd_valid_next;

  assign wr_fire = i_wr_valid && o_wr_ready;
  // read register empty or draining this cycle
  assign out_load = !o_rd_valid || i_rd_ready;
  assign pop = out_load && (mem_cnt != '0);
  // empty storage, write goes straight to the read register
  assign bypass = out_load && (mem_cnt == '0) && wr_fire;
  assign push = wr_fire && !bypass;
  assign rd_valid_next = out_load ? (pop || bypass) : o_rd_valid;

  always_comb begin
    mem_cnt_next = mem_cnt;
    if (push && !pop)
      mem_cnt_next = mem_cnt + rr_pkg::fifo_cnt_t'(1);
    else if (!push && pop)
      mem_cnt_next = mem_cnt - rr_pkg::fifo_cnt_t'(1);
    occ_next = mem_cnt_next + rr_pkg::fifo_cnt_t'(rd_valid_next);
  end

  //////////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      mem_cnt    <= '0;
      o_rd_valid <= 1'b0;
      o_wr_ready <= 1'b0;
    end else begin
      if (push)
        wr_ptr <= (wr_ptr == rr_pkg::fifo_ptr_t'(rr_pkg::FIFO_DEPTH - 1)) ?
                  '0 : wr_ptr + rr_pkg::fifo_ptr_t'(1);
      if (pop)
        rd_ptr <= (rd_ptr == rr_pkg::fifo_ptr_t'(rr_pkg::FIFO_DEPTH - 1)) ?
                  '0 : rd_ptr + rr_pkg::fifo_ptr_t'(1);
      mem_cnt    <= mem_cnt_next;
      o_rd_valid <= rd_valid_next;
      // ready whenever a slot is left next cycle
      o_wr_ready <= (occ_next != rr_pkg::fifo_cnt_t'(rr_pkg::FIFO_DEPTH));
    end
  end

  // payload path
  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= i_wr_word;
    if (pop)
      o_rd_word <= mem[rd_ptr];
    else if (bypass)
      o_rd_word <= i_wr_word;
  end

  // registered ready must never admit a word into a full FIFO
  a_no_write_when_full: assert property (@(posedge clk) disable iff (!rstn)
    wr_fire |-> ((mem_cnt + rr_pkg::fifo_cnt_t'(o_rd_valid)) <
                 rr_pkg::fifo_cnt_t'(rr_pkg::FIFO_DEPTH)));

endmodule

`default_nettype wire

// ==== hw/rr_replay_fork.sv ====
////////////////////////////////////////////////////////////////////////////
// replay word fork to channel replayers
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module rr_replay_fork (
  input  wire                               clk,
  input  wire                               rstn,
  // word from the FIFO
  input  wire                               i_valid,
  input  wire rr_pkg::replay_word_t         i_word,
  output logic                              o_ready,
  // one handshake per channel
  output logic [rr_pkg::CHANNEL_CNT-1:0]    o_ch_valid,
  output rr_pkg::replay_word_t              o_ch_pkt,
  input  wire [rr_pkg::CHANNEL_CNT-1:0]     i_ch_ready
);

  // channels that already took the current word
  logic [rr_pkg::CHANNEL_CNT-1:0] delivered;
  logic [rr_pkg::CHANNEL_CNT-1:0] ch_xfer;
  logic [rr_pkg::CHANNEL_CNT-1:0] ch_done;

  //////////////////////////////////////////////////////////////////////////
  // offer and accept
  //////////////////////////////////////////////////////////////////////////

  // offer only to channels still waiting
  assign o_ch_valid = {rr_pkg::CHANNEL_CNT{i_valid}} & ~delivered;
  // every channel sees its own slice of the word
  assign o_ch_pkt = i_word;

  assign ch_xfer = o_ch_valid & i_ch_ready;
  // taken earlier or taking now
  assign ch_done = delivered | ch_xfer;

  // pop the FIFO once the last outstanding channel transfers
  assign o_ready = i_valid && (&ch_done);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      delivered <= '0;
    end else if (o_ready) begin
      // word retired, next word starts clean
      delivered <= '0;
    end else begin
      delivered <= ch_done;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////////

  // a partly delivered word must be held by the FIFO
  a_word_held: assert property (@(posedge clk) disable iff (!rstn)
    (|delivered) |-> (i_valid && $stable(i_word)));

  for (genvar c = 0; c < rr_pkg::CHANNEL_CNT; c++) begin : g_chk
    // each channel gets a word exactly once
    a_no_redeliver: assert property (@(posedge clk) disable iff (!rstn)
      (ch_xfer[c] && !o_ready) |=> !ch_xfer[c]);
  end

endmodule

`default_nettype wire

// ==== hw/rr_channel_replayer.sv ====
////////////////////////////////////////////////////////////////////////////
// per-channel replayer with happen-before gating
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module rr_channel_replayer (
  input  wire                     clk,
  input  wire                     rstn,
  // packet from the fork
  input  wire                     i_in_valid,
  input  wire rr_pkg::chan_pkt_t  i_pkt,
  output logic                    o_in_ready,
  // runtime end strobes, never stalled
  input  wire rr_pkg::loge_vec_t  i_rt_loge_valid,
  // replayed payload
  output logic                    o_out_valid,
  input  wire                     i_out_ready,
  output rr_pkg::logb_data_t      o_out_data
);

  rr_pkg::rr_state_t state;
  rr_pkg::rr_state_t state_next;
  // head of the buffer, drives the output
  rr_pkg::chan_pkt_t out_q;
  // second slot, filled only when the head stalls
  rr_pkg::chan_pkt_t spare_q;

  logic insert;
  logic remove_logb;
  logic remove_loge;
  logic remove;

  // end event counters, one per channel
  rr_pkg::pkt_cnt_t rt_cnt [rr_pkg::CHANNEL_CNT];
  rr_pkg::pkt_cnt_t replay_cnt [rr_pkg::CHANNEL_CNT];
  rr_pkg::pkt_cnt_t replay_cnt_next [rr_pkg::CHANNEL_CNT];
  rr_pkg::pkt_cnt_t cnt_diff [rr_pkg::CHANNEL_CNT];
  logic [rr_pkg::CHANNEL_CNT-1:0] chan_ok;
  logic ok_to_replay;

  //////////////////////////////////////////////////////////////////////////
  // buffer FSM
  //////////////////////////////////////////////////////////////////////////

  assign insert = i_in_valid && o_in_ready;
  // payload handed out
  assign remove_logb = o_out_valid && i_out_ready;
  // loge only packet, retired right away
  assign remove_loge = (state != rr_pkg::EMPTY) && !out_q.logb_valid;
  assign remove = remove_logb || remove_loge;

  always_comb begin
    state_next = state;
    case (state)
      rr_pkg::EMPTY: begin
        // load
        if (insert)
          state_next = rr_pkg::BUSY;
      end
      rr_pkg::BUSY: begin
        // fill on a stalled head, unload when drained
        if (insert && !remove)
          state_next = rr_pkg::FULL;
        else if (!insert && remove)
          state_next = rr_pkg::EMPTY;
      end
      rr_pkg::FULL: begin
        // flush the spare into the head
        if (!insert && remove)
          state_next = rr_pkg::BUSY;
      end
      default: state_next = state;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state      <= rr_pkg::EMPTY;
      o_in_ready <= 1'b0;
    end else begin
      state      <= state_next;
      o_in_ready <= (state_next != rr_pkg::FULL);
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if ((state == rr_pkg::BUSY) && (state_next == rr_pkg::FULL))
      spare_q <= i_pkt;
    if (state_next == rr_pkg::BUSY) begin
      if (state == rr_pkg::FULL)
        out_q <= spare_q;
      else if (insert)
        // load or flow
        out_q <= i_pkt;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // end event counters
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int c = 0; c < rr_pkg::CHANNEL_CNT; c++) begin
        rt_cnt[c]     <= '0;
        replay_cnt[c] <= '0;
      end
    end else begin
      for (int c = 0; c < rr_pkg::CHANNEL_CNT; c++) begin
        rt_cnt[c] <= rt_cnt[c] + rr_pkg::pkt_cnt_t'(i_rt_loge_valid[c]);
        // retired packet's markers
        if (remove)
          replay_cnt[c] <= replay_cnt_next[c];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // happen-before check
  //////////////////////////////////////////////////////////////////////////

  for (genvar c = 0; c < rr_pkg::CHANNEL_CNT; c++) begin : g_cmp
    // replay count including the head's own markers
    assign replay_cnt_next[c] = replay_cnt[c] + rr_pkg::pkt_cnt_t'(out_q.loge_valid[c]);
    // wraps safely inside the in-flight window
    assign cnt_diff[c] = rt_cnt[c] - replay_cnt_next[c];
    // sign clear, runtime caught up on this channel
    assign chan_ok[c] = !cnt_diff[c][rr_pkg::PKT_CNT_WIDTH-1];
  end

  assign ok_to_replay = &chan_ok;

  assign o_out_valid = (state != rr_pkg::EMPTY) && out_q.logb_valid && ok_to_replay;
  assign o_out_data = out_q.logb_data;

  //////////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////////

  // an offered payload stays put until taken
  a_out_hold: assert property (@(posedge clk) disable iff (!rstn)
    (o_out_valid && !i_out_ready) |=> (o_out_valid && $stable(o_out_data)));

  a_state_legal: assert property (@(posedge clk) disable iff (!rstn)
    state != rr_pkg::rr_state_t'(2'b11));

endmodule

`default_nettype wire

// ==== hw/rr_replay_top.sv ====
////////////////////////////////////////////////////////////////////////////
// replay subsystem top
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module rr_replay_top (
  input  wire                                       clk,
  input  wire                                       rstn,
  // recorded log stream
  input  wire                                       i_replay_valid,
  input  wire rr_pkg::replay_word_t                 i_replay_word,
  output wire                                       o_replay_ready,
  // runtime end strobes
  input  wire rr_pkg::loge_vec_t                    i_rt_loge_valid,
  // replayed payloads, one stream per channel
  output wire [rr_pkg::CHANNEL_CNT-1:0]             o_out_valid,
  input  wire [rr_pkg::CHANNEL_CNT-1:0]             i_out_ready,
  output wire rr_pkg::logb_data_t [rr_pkg::CHANNEL_CNT-1:0] o_out_data
);

  // FIFO to fork
  wire                            fifo_valid;
  wire                            fifo_ready;
  wire rr_pkg::replay_word_t      fifo_word;

  // fork to replayers
  wire [rr_pkg::CHANNEL_CNT-1:0]  ch_valid;
  wire [rr_pkg::CHANNEL_CNT-1:0]  ch_ready;
  wire rr_pkg::replay_word_t      ch_pkt;

  rr_replay_fifo u_fifo (
    .clk        (clk),
    .rstn       (rstn),
    .i_wr_valid (i_replay_valid),
    .i_wr_word  (i_replay_word),
    .o_wr_ready (o_replay_ready),
    .o_rd_valid (fifo_valid),
    .o_rd_word  (fifo_word),
    .i_rd_ready (fifo_ready)
  );

  rr_replay_fork u_fork (
    .clk        (clk),
    .rstn       (rstn),
    .i_valid    (fifo_valid),
    .i_word     (fifo_word),
    .o_ready    (fifo_ready),
    .o_ch_valid (ch_valid),
    .o_ch_pkt   (ch_pkt),
    .i_ch_ready (ch_ready)
  );

  // one replayer per channel, all watching every runtime strobe
  for (genvar c = 0; c < rr_pkg::CHANNEL_CNT; c++) begin : g_chan
    rr_channel_replayer u_chan (
      .clk             (clk),
      .rstn            (rstn),
      .i_in_valid      (ch_valid[c]),
      .i_pkt           (ch_pkt[c]),
      .o_in_ready      (ch_ready[c]),
      .i_rt_loge_valid (i_rt_loge_valid),
      .o_out_valid     (o_out_valid[c]),
      .i_out_ready     (i_out_ready[c]),
      .o_out_data      (o_out_data[c])
    );
  end

endmodule

`default_nettype wire

// ==== testbench/tb_rr_replay.sv ====
////////////////////////////////////////////////////////////////////////////
// replay subsystem testbench
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_rr_replay;

  localparam int NCH = rr_pkg::CHANNEL_CNT;
  // total words sent sets the watchdog length
  localparam int TOTAL_WORDS = 36;
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 40 + 400;

  logic                         clk = 1'b0;
  logic                         rstn;
  logic                         i_replay_valid;
  rr_pkg::replay_word_t         i_replay_word;
  wire                          o_replay_ready;
  rr_pkg::loge_vec_t            i_rt_loge_valid;
  wire [NCH-1:0]                o_out_valid;
  logic [NCH-1:0]               i_out_ready;
  wire rr_pkg::logb_data_t [NCH-1:0] o_out_data;

  int seed = 32'h4cba;
  int error_cnt = 0;
  int check_cnt = 0;
  // every packet sent per channel in send order
  rr_pkg::chan_pkt_t exp_q [NCH][$];
  // runtime strobes and per-replayer replay markers
  int rt_model [NCH];
  int rep_model [NCH][NCH];
  // previous stalled offer per channel
  logic [NCH-1:0]     stall_seen;
  rr_pkg::logb_data_t stall_data [NCH];

  always #4 clk = ~clk;

  rr_replay_top u_rr_replay_top (
    .clk             (clk),
    .rstn            (rstn),
    .i_replay_valid  (i_replay_valid),
    .i_replay_word   (i_replay_word),
    .o_replay_ready  (o_replay_ready),
    .i_rt_loge_valid (i_rt_loge_valid),
    .o_out_valid     (o_out_valid),
    .i_out_ready     (i_out_ready),
    .o_out_data      (o_out_data)
  );

  //////////////////////////////////////////////////////////////////////////
  // checking and model
  //////////////////////////////////////////////////////////////////////////

  task automatic check_eq(input string name, input int exp, input int act);
    check_cnt++;
    if (exp !== act) begin
      error_cnt++;
      $display("CHECK FAILED time %0t: %s expected %0h got %0h", $time, name, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    error_cnt++;
    $display("ERROR time %0t: %s", $time, msg);
  endtask

  // no-logb packets leave silently but their markers count
  task automatic retire_dropped(input int c);
    rr_pkg::chan_pkt_t head;
    while (exp_q[c].size() > 0 && !exp_q[c][0].logb_valid) begin
      head = exp_q[c].pop_front();
      for (int k = 0; k < NCH; k++)
        rep_model[c][k] += int'(head.loge_valid[k]);
    end
  endtask

  task automatic take_output(input int c, input rr_pkg::logb_data_t data);
    rr_pkg::chan_pkt_t head;
    retire_dropped(c);
    if (exp_q[c].size() == 0) begin
      report_error($sformatf("unexpected output on channel %0d", c));
      return;
    end
    head = exp_q[c].pop_front();
    // runtime must cover the log up to this packet
    for (int k = 0; k < NCH; k++)
      if (rt_model[k] < rep_model[c][k] + int'(head.loge_valid[k]))
        report_error($sformatf("channel %0d released ahead of channel %0d end events", c, k));
    check_eq($sformatf("o_out_data[%0d]", c), int'(head.logb_data), int'(data));
    for (int k = 0; k < NCH; k++)
      rep_model[c][k] += int'(head.loge_valid[k]);
  endtask

  // outputs sampled mid cycle before the handshake edge
  always @(negedge clk) begin
    if (rstn) begin
      for (int c = 0; c < NCH; c++) begin
        if (stall_seen[c]) begin
          check_eq($sformatf("o_out_valid[%0d]", c), 1, int'(o_out_valid[c]));
          check_eq($sformatf("o_out_data[%0d]", c), int'(stall_data[c]), int'(o_out_data[c]));
        end
        stall_seen[c] = o_out_valid[c] && !i_out_ready[c];
        stall_data[c] = o_out_data[c];
        if (o_out_valid[c] && i_out_ready[c])
          take_output(c, o_out_data[c]);
      end
      // strobes reach the DUT counters at the next edge
      for (int k = 0; k < NCH; k++)
        rt_model[k] += int'(i_rt_loge_valid[k]);
    end
  end

  function automatic int pending_logb();
    int n;
    n = 0;
    for (int c = 0; c < NCH; c++)
      for (int i = 0; i < exp_q[c].size(); i++)
        if (exp_q[c][i].logb_valid)
          n++;
    return n;
  endfunction

  // strobes on channel k still owed before channel c's next payload
  function automatic int strobes_needed(input int c, input int k);
    int r;
    r = rep_model[c][k];
    for (int i = 0; i < exp_q[c].size(); i++) begin
      r += int'(exp_q[c][i].loge_valid[k]);
      if (exp_q[c][i].logb_valid)
        break;
    end
    return (r > rt_model[k]) ? r - rt_model[k] : 0;
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // drivers called 1 ns after a rising edge
  //////////////////////////////////////////////////////////////////////////

  function automatic rr_pkg::chan_pkt_t make_pkt(input logic logb, input rr_pkg::loge_vec_t loge);
    rr_pkg::chan_pkt_t p;
    p.logb_valid = logb;
    p.logb_data = rr_pkg::logb_data_t'($random(seed));
    p.loge_valid = loge;
    return p;
  endfunction

  task automatic send_word(input rr_pkg::replay_word_t word);
    int   waited;
    logic taken;
    waited = 0;
    taken = 1'b0;
    i_replay_valid = 1'b1;
    i_replay_word = word;
    while (!taken && waited < 200) begin
      @(negedge clk);
      taken = o_replay_ready;
      if (taken)
        for (int c = 0; c < NCH; c++)
          exp_q[c].push_back(word[c]);
      @(posedge clk);
      #1;
      waited++;
    end
    i_replay_valid = 1'b0;
    if (!taken)
      report_error("replay word never accepted by the input FIFO");
  endtask

  task automatic wait_input_ready(input int limit, output logic ok);
    int n;
    n = 0;
    while (!o_replay_ready && n < limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    ok = o_replay_ready;
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (pending_logb() != 0 && n < limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (pending_logb() != 0)
      report_error("expected payloads never came out");
  endtask

  task automatic expect_quiet(input logic [NCH-1:0] mask, input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_eq("o_out_valid", 0, int'(o_out_valid & mask));
      @(posedge clk);
      #1;
    end
  endtask

  task automatic pulse_rt(input int k);
    i_rt_loge_valid = rr_pkg::loge_vec_t'(1 << k);
    @(posedge clk);
    #1;
    i_rt_loge_valid = '0;
    @(posedge clk);
    #1;
  endtask

  //////////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////////

  task automatic in_order_stream();
    rr_pkg::replay_word_t w;
    i_out_ready = '1;
    expect_quiet('1, 5);
    for (int n = 0; n < 8; n++) begin
      for (int c = 0; c < NCH; c++)
        w[c] = make_pkt(1'b1, '0);
      send_word(w);
    end
    wait_drain(200);
  endtask

  task automatic happen_before_gate();
    rr_pkg::replay_word_t w;
    // ch0 payload waits on one channel 1 end while ch1 only logs the marker
    w[0] = make_pkt(1'b1, 2'b10);
    w[1] = make_pkt(1'b0, 2'b10);
    send_word(w);
    expect_quiet(2'b01, 20);
    pulse_rt(1);
    wait_drain(50);
  endtask

  task automatic dropped_loge_gate();
    rr_pkg::replay_word_t w;
    int need;
    for (int n = 0; n < 2; n++) begin
      w[0] = make_pkt(1'b0, 2'b01);
      w[1] = make_pkt(1'b0, 2'b01);
      send_word(w);
    end
    w[0] = make_pkt(1'b1, '0);
    w[1] = make_pkt(1'b1, '0);
    send_word(w);
    expect_quiet('1, 10);
    need = strobes_needed(0, 0);
    if (strobes_needed(1, 0) > need)
      need = strobes_needed(1, 0);
    repeat (need) pulse_rt(0);
    wait_drain(50);
  endtask

  task automatic fork_backpressure();
    rr_pkg::replay_word_t w;
    logic ok;
    int   sent;
    sent = 0;
    ok = 1'b1;
    // fill with ch1 stalled until the input stops taking words
    i_out_ready = 2'b01;
    while (ok && sent < 20) begin
      wait_input_ready(12, ok);
      if (ok) begin
        for (int c = 0; c < NCH; c++)
          w[c] = make_pkt(1'b1, '0);
        send_word(w);
        sent++;
      end
    end
    check_eq("o_replay_ready", 0, int'(o_replay_ready));
    check_eq("words held for channel 1", rr_pkg::FIFO_DEPTH + 2, exp_q[1].size());
    // ch0 only lacks the words queued behind the partly delivered head
    check_eq("words held for channel 0", rr_pkg::FIFO_DEPTH - 1, exp_q[0].size());
    i_out_ready = '1;
    wait_drain(100);
  endtask

  task automatic stall_stability();
    rr_pkg::replay_word_t w;
    int n;
    i_out_ready = '0;
    for (int i = 0; i < 6; i++) begin
      for (int c = 0; c < NCH; c++)
        w[c] = make_pkt(1'b1, '0);
      send_word(w);
    end
    n = 0;
    // random stall followed by a single ready cycle
    while (pending_logb() != 0 && n < 40) begin
      repeat (int'($unsigned($random(seed)) % 8) + 1) begin
        @(posedge clk);
        #1;
      end
      i_out_ready = '1;
      @(posedge clk);
      #1;
      i_out_ready = '0;
      n++;
    end
    i_out_ready = '1;
    wait_drain(50);
  endtask

  task automatic random_drain();
    rr_pkg::replay_word_t w;
    int   idx;
    int   n;
    logic taken;
    idx = 0;
    n = 0;
    while ((idx < 12 || pending_logb() != 0) && n < 600) begin
      i_out_ready = rr_pkg::loge_vec_t'($random(seed));
      if (idx < 12 && !i_replay_valid) begin
        // mostly payloads with now and then a silent packet
        for (int c = 0; c < NCH; c++)
          w[c] = make_pkt(($random(seed) & 3) != 0, '0);
        i_replay_valid = 1'b1;
        i_replay_word = w;
      end
      @(negedge clk);
      taken = i_replay_valid && o_replay_ready;
      if (taken) begin
        for (int c = 0; c < NCH; c++)
          exp_q[c].push_back(i_replay_word[c]);
        idx++;
      end
      @(posedge clk);
      #1;
      if (taken)
        i_replay_valid = 1'b0;
      n++;
    end
    i_out_ready = '1;
    // idle window to catch any extra output
    repeat (20) @(posedge clk);
    #1;
    for (int c = 0; c < NCH; c++) begin
      retire_dropped(c);
      check_eq($sformatf("exp_q[%0d] size", c), 0, exp_q[c].size());
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // run
  //////////////////////////////////////////////////////////////////////////

  initial begin
    rstn = 1'b0;
    i_replay_valid = 1'b0;
    i_replay_word = '0;
    i_rt_loge_valid = '0;
    i_out_ready = '0;
    stall_seen = '0;
    for (int k = 0; k < NCH; k++) begin
      rt_model[k] = 0;
      for (int c = 0; c < NCH; c++)
        rep_model[c][k] = 0;
    end
    repeat (2) @(posedge clk);
    #1;
    rstn = 1'b1;
    in_order_stream();
    happen_before_gate();
    dropped_loge_gate();
    fork_backpressure();
    stall_stability();
    random_drain();
    $display("summary: %0d checks, %0d errors", check_cnt, error_cnt);
    if (error_cnt == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
hw/rr_pkg.sv
hw/rr_replay_fifo.sv
hw/rr_replay_fork.sv
hw/rr_channel_replayer.sv
hw/rr_replay_top.sv
testbench/tb_rr_replay.sv

// ==== run.sh ====
#!/bin/sh
# build and run the replay testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module tb_rr_replay \
  -Mdir build/obj_dir -o sim_rr_replay
# the log decides pass or fail, not the simulator status
./build/obj_dir/sim_rr_replay > sim.log 2>&1 || true
cat sim.log
grep -qx "TEST PASS" sim.log
